//--- rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    // one instruction word, six ways to read it
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_br    = 7'b1100011;

    localparam logic [3:0] alu_add  = 4'd0;
    localparam logic [3:0] alu_sub  = 4'd1;
    localparam logic [3:0] alu_sll  = 4'd2;
    localparam logic [3:0] alu_slt  = 4'd3;
    localparam logic [3:0] alu_sltu = 4'd4;
    localparam logic [3:0] alu_xor  = 4'd5;
    localparam logic [3:0] alu_srl  = 4'd6;
    localparam logic [3:0] alu_sra  = 4'd7;
    localparam logic [3:0] alu_or   = 4'd8;
    localparam logic [3:0] alu_and  = 4'd9;

    localparam logic a_sel_rs1  = 1'b0;
    localparam logic a_sel_pc   = 1'b1;
    localparam logic b_sel_rs2  = 1'b0;
    localparam logic b_sel_imm  = 1'b1;
    localparam logic wb_sel_alu = 1'b0;
    localparam logic wb_sel_pc4 = 1'b1; // link value for jumps

    // branch compares are the funct3 encodings
    localparam logic [2:0] beq  = 3'b000;
    localparam logic [2:0] bne  = 3'b001;
    localparam logic [2:0] blt  = 3'b100;
    localparam logic [2:0] bge  = 3'b101;
    localparam logic [2:0] bltu = 3'b110;
    localparam logic [2:0] bgeu = 3'b111;

endpackage

`default_nettype wire

//--- regfile.sv
`default_nettype none

module regfile (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [4:0]  rs1_addr,
    input  wire logic [4:0]  rs2_addr,
    output logic      [31:0] rs1_data,
    output logic      [31:0] rs2_data,
    input  wire logic        we,
    input  wire logic [4:0]  rd,
    input  wire logic [31:0] wd
);

    logic [31:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

    // write-first so a same-cycle write is visible to decode
    always_comb begin
        if (rs1_addr == 5'd0)                rs1_data = 32'd0;
        else if (we && rd == rs1_addr)       rs1_data = wd;
        else                                 rs1_data = regs[rs1_addr];

        if (rs2_addr == 5'd0)                rs2_data = 32'd0;
        else if (we && rd == rs2_addr)       rs2_data = wd;
        else                                 rs2_data = regs[rs2_addr];
    end

    // a stored value reads back on the next cycle
    a_read_back: assert property (@(posedge clk) disable iff (rst)
        $past(we) && !$past(rst) && $past(rd) != 5'd0 && rs1_addr == $past(rd)
        && !(we && rd == rs1_addr) |-> rs1_data == $past(wd));

endmodule

`default_nettype wire

//--- id_decode.sv
`default_nettype none

module id_decode (
    input  wire logic [31:0] instr,
    input  wire logic        instr_valid,
    input  wire logic [31:0] instr_pc,
    output logic      [4:0]  rs1_addr,
    output logic      [4:0]  rs2_addr,
    input  wire logic [31:0] rs1_rdata,
    input  wire logic [31:0] rs2_rdata,
    output logic             valid,
    output logic      [31:0] pc,
    output logic      [31:0] rs1_data,
    output logic      [31:0] rs2_data,
    output logic      [31:0] imm,
    output logic      [4:0]  rd,
    output logic             reg_we,
    output logic      [3:0]  alu_op,
    output logic             a_sel,
    output logic             b_sel,
    output logic             wb_sel,
    output logic             is_branch,
    output logic             is_jal,
    output logic             is_jalr,
    output logic      [2:0]  funct3
);

    rv32i_pkg::instr_u iw;
    logic [31:0] imm_i, imm_u, imm_b, imm_j;
    logic [3:0]  alu_fn;
    logic        known;
    logic        we_dec;

    assign iw = instr;

    assign imm_i = {{20{iw.i_fmt.imm_11_0[11]}}, iw.i_fmt.imm_11_0};
    assign imm_u = {iw.u_fmt.imm_31_12, 12'd0};
    assign imm_b = {{19{iw.b_fmt.imm_12}}, iw.b_fmt.imm_12, iw.b_fmt.imm_11,
                    iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
    assign imm_j = {{11{iw.j_fmt.imm_20}}, iw.j_fmt.imm_20, iw.j_fmt.imm_19_12,
                    iw.j_fmt.imm_11, iw.j_fmt.imm_10_1, 1'b0};

    // lui reads x0 so the alu just adds the immediate
    assign rs1_addr = (iw.r_fmt.opcode == rv32i_pkg::op_lui) ? 5'd0 : iw.r_fmt.rs1;
    assign rs2_addr = iw.r_fmt.rs2;
    assign rs1_data = rs1_rdata;
    assign rs2_data = rs2_rdata;
    assign pc       = instr_pc;
    assign rd       = iw.r_fmt.rd;
    assign funct3   = iw.r_fmt.funct3;

    always_comb begin
        case (iw.r_fmt.funct3)
            3'b000: begin
                if (iw.r_fmt.opcode == rv32i_pkg::op_reg && iw.r_fmt.funct7[5])
                    alu_fn = rv32i_pkg::alu_sub;
                else
                    alu_fn = rv32i_pkg::alu_add;
            end
            3'b001:  alu_fn = rv32i_pkg::alu_sll;
            3'b010:  alu_fn = rv32i_pkg::alu_slt;
            3'b011:  alu_fn = rv32i_pkg::alu_sltu;
            3'b100:  alu_fn = rv32i_pkg::alu_xor;
            3'b101:  alu_fn = iw.r_fmt.funct7[5] ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
            3'b110:  alu_fn = rv32i_pkg::alu_or;
            default: alu_fn = rv32i_pkg::alu_and;
        endcase
    end

    always_comb begin
        known     = 1'b1;
        we_dec    = 1'b0;
        imm       = imm_i;
        alu_op    = rv32i_pkg::alu_add;
        a_sel     = rv32i_pkg::a_sel_rs1;
        b_sel     = rv32i_pkg::b_sel_imm;
        wb_sel    = rv32i_pkg::wb_sel_alu;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        case (iw.r_fmt.opcode)
            rv32i_pkg::op_reg: begin
                we_dec = 1'b1;
                alu_op = alu_fn;
                b_sel  = rv32i_pkg::b_sel_rs2;
            end
            rv32i_pkg::op_imm: begin
                we_dec = 1'b1;
                alu_op = alu_fn;
            end
            rv32i_pkg::op_lui: begin
                we_dec = 1'b1;
                imm    = imm_u;
            end
            rv32i_pkg::op_auipc: begin
                we_dec = 1'b1;
                imm    = imm_u;
                a_sel  = rv32i_pkg::a_sel_pc;
            end
            rv32i_pkg::op_jal: begin
                we_dec = 1'b1;
                imm    = imm_j;
                wb_sel = rv32i_pkg::wb_sel_pc4;
                is_jal = 1'b1;
            end
            rv32i_pkg::op_jalr: begin
                we_dec  = 1'b1;
                wb_sel  = rv32i_pkg::wb_sel_pc4;
                is_jalr = 1'b1;
            end
            rv32i_pkg::op_br: begin
                imm       = imm_b;
                b_sel     = rv32i_pkg::b_sel_rs2;
                is_branch = 1'b1; // funct3 is the compare code
            end
            default: known = 1'b0;
        endcase
    end

    assign valid  = instr_valid & known;
    assign reg_we = we_dec & valid;

endmodule

`default_nettype wire

//--- id_ex_reg.sv
`default_nettype none

module id_ex_reg (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        stall,
    input  wire logic        flush,
    input  wire logic        id_valid,
    input  wire logic [31:0] id_pc,
    input  wire logic [31:0] id_instr,
    input  wire logic [31:0] id_rs1_data,
    input  wire logic [31:0] id_rs2_data,
    input  wire logic [4:0]  id_rs1_addr,
    input  wire logic [4:0]  id_rs2_addr,
    input  wire logic [31:0] id_imm,
    input  wire logic [4:0]  id_rd,
    input  wire logic        id_reg_we,
    input  wire logic [3:0]  id_alu_op,
    input  wire logic        id_a_sel,
    input  wire logic        id_b_sel,
    input  wire logic        id_wb_sel,
    input  wire logic        id_is_branch,
    input  wire logic        id_is_jal,
    input  wire logic        id_is_jalr,
    input  wire logic [2:0]  id_funct3,
    output logic             ex_valid,
    output logic      [31:0] ex_pc,
    output logic      [31:0] ex_instr,
    output logic      [31:0] ex_rs1_data,
    output logic      [31:0] ex_rs2_data,
    output logic      [4:0]  ex_rs1_addr,
    output logic      [4:0]  ex_rs2_addr,
    output logic      [31:0] ex_imm,
    output logic      [4:0]  ex_rd,
    output logic             ex_reg_we,
    output logic      [3:0]  ex_alu_op,
    output logic             ex_a_sel,
    output logic             ex_b_sel,
    output logic             ex_wb_sel,
    output logic             ex_is_branch,
    output logic             ex_is_jal,
    output logic             ex_is_jalr,
    output logic      [2:0]  ex_funct3
);

    logic load;

    assign load = ~stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid     <= 1'b0;
            ex_pc        <= 32'd0;
            ex_instr     <= 32'd0;
            ex_rs1_data  <= 32'd0;
            ex_rs2_data  <= 32'd0;
            ex_rs1_addr  <= 5'd0;
            ex_rs2_addr  <= 5'd0;
            ex_imm       <= 32'd0;
            ex_rd        <= 5'd0;
            ex_reg_we    <= 1'b0;
            ex_alu_op    <= rv32i_pkg::alu_add;
            ex_a_sel     <= 1'b0;
            ex_b_sel     <= 1'b0;
            ex_wb_sel    <= 1'b0;
            ex_is_branch <= 1'b0;
            ex_is_jal    <= 1'b0;
            ex_is_jalr   <= 1'b0;
            ex_funct3    <= 3'd0;
        end else if (flush) begin
            // bubble, the slot behind a taken branch or jump dies here
            ex_valid    <= 1'b0;
            ex_reg_we   <= 1'b0;
            ex_alu_op   <= rv32i_pkg::alu_add;
            ex_rd       <= 5'd0;
            ex_rs1_data <= 32'd0;
            ex_rs2_data <= 32'd0;
        end else if (load) begin
            ex_valid     <= id_valid;
            ex_pc        <= id_pc;
            ex_instr     <= id_instr;
            ex_rs1_data  <= id_rs1_data;
            ex_rs2_data  <= id_rs2_data;
            ex_rs1_addr  <= id_rs1_addr;
            ex_rs2_addr  <= id_rs2_addr;
            ex_imm       <= id_imm;
            ex_rd        <= id_rd;
            ex_reg_we    <= id_reg_we;
            ex_alu_op    <= id_alu_op;
            ex_a_sel     <= id_a_sel;
            ex_b_sel     <= id_b_sel;
            ex_wb_sel    <= id_wb_sel;
            ex_is_branch <= id_is_branch;
            ex_is_jal    <= id_is_jal;
            ex_is_jalr   <= id_is_jalr;
            ex_funct3    <= id_funct3;
        end
    end

    // a flush over a held slot would drop the branch itself
    a_no_flush_in_stall: assert property (@(posedge clk) disable iff (rst)
        flush |-> !stall);

endmodule

`default_nettype wire

//--- ex_stage.sv
`default_nettype none

module ex_stage (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        stall,
    input  wire logic        ex_valid,
    input  wire logic [31:0] ex_pc,
    input  wire logic [31:0] ex_instr,
    input  wire logic [31:0] ex_rs1_data,
    input  wire logic [31:0] ex_rs2_data,
    input  wire logic [4:0]  ex_rs1_addr,
    input  wire logic [4:0]  ex_rs2_addr,
    input  wire logic [31:0] ex_imm,
    input  wire logic [4:0]  ex_rd,
    input  wire logic        ex_reg_we,
    input  wire logic [3:0]  ex_alu_op,
    input  wire logic        ex_a_sel,
    input  wire logic        ex_b_sel,
    input  wire logic        ex_wb_sel,
    input  wire logic        ex_is_branch,
    input  wire logic        ex_is_jal,
    input  wire logic        ex_is_jalr,
    input  wire logic [2:0]  ex_funct3,
    output logic             flush,
    output logic             wb_we,
    output logic      [4:0]  wb_rd,
    output logic      [31:0] wb_data,
    output logic             retire_valid,
    output logic      [31:0] retire_pc,
    output logic      [31:0] retire_instr,
    output logic             redirect,
    output logic      [31:0] redirect_pc
);

    logic [31:0] op1, op2, alu_a, alu_b, alu_y;
    logic [31:0] target, result;
    logic        wb_live; // last retired write, kept across stall bubbles
    logic        br_true, take;

    // forward from the retire register, x0 never
    assign op1 = (wb_live && wb_rd != 5'd0 && wb_rd == ex_rs1_addr) ? wb_data : ex_rs1_data;
    assign op2 = (wb_live && wb_rd != 5'd0 && wb_rd == ex_rs2_addr) ? wb_data : ex_rs2_data;

    assign alu_a = (ex_a_sel == rv32i_pkg::a_sel_pc)  ? ex_pc  : op1;
    assign alu_b = (ex_b_sel == rv32i_pkg::b_sel_imm) ? ex_imm : op2;

    always_comb begin
        case (ex_alu_op)
            rv32i_pkg::alu_sub:  alu_y = alu_a - alu_b;
            rv32i_pkg::alu_sll:  alu_y = alu_a << alu_b[4:0];
            rv32i_pkg::alu_slt:  alu_y = {31'd0, $signed(alu_a) < $signed(alu_b)};
            rv32i_pkg::alu_sltu: alu_y = {31'd0, alu_a < alu_b};
            rv32i_pkg::alu_xor:  alu_y = alu_a ^ alu_b;
            rv32i_pkg::alu_srl:  alu_y = alu_a >> alu_b[4:0];
            rv32i_pkg::alu_sra:  alu_y = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            rv32i_pkg::alu_or:   alu_y = alu_a | alu_b;
            rv32i_pkg::alu_and:  alu_y = alu_a & alu_b;
            default:             alu_y = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (ex_funct3)
            rv32i_pkg::beq:  br_true = op1 == op2;
            rv32i_pkg::bne:  br_true = op1 != op2;
            rv32i_pkg::blt:  br_true = $signed(op1) < $signed(op2);
            rv32i_pkg::bge:  br_true = $signed(op1) >= $signed(op2);
            rv32i_pkg::bltu: br_true = op1 < op2;
            rv32i_pkg::bgeu: br_true = op1 >= op2;
            default:         br_true = 1'b0;
        endcase
    end

    assign take   = ex_valid & ((ex_is_branch & br_true) | ex_is_jal | ex_is_jalr);
    assign target = ex_is_jalr ? ((op1 + ex_imm) & ~32'd1) : (ex_pc + ex_imm);
    assign result = (ex_wb_sel == rv32i_pkg::wb_sel_pc4) ? (ex_pc + 32'd4) : alu_y;
    assign flush  = take & ~stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            retire_pc    <= 32'd0;
            retire_instr <= 32'd0;
            wb_we        <= 1'b0;
            wb_rd        <= 5'd0;
            wb_data      <= 32'd0;
            wb_live      <= 1'b0;
            redirect     <= 1'b0;
            redirect_pc  <= 32'd0;
        end else if (stall) begin
            retire_valid <= 1'b0; // ID/EX holds, so nothing retires
            wb_we        <= 1'b0;
            redirect     <= 1'b0;
        end else begin
            retire_valid <= ex_valid;
            retire_pc    <= ex_pc;
            retire_instr <= ex_instr;
            wb_we        <= ex_reg_we;
            wb_rd        <= ex_rd;
            wb_data      <= result;
            wb_live      <= ex_reg_we;
            redirect     <= take;
            redirect_pc  <= target;
        end
    end

    // the slot behind a taken branch or jump arrives as a bubble
    a_flush_bubble: assert property (@(posedge clk) disable iff (rst)
        flush |=> !ex_valid && !ex_reg_we);

endmodule

`default_nettype wire

//--- exec_pipe_top.sv
`default_nettype none

module exec_pipe_top (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        instr_valid,
    input  wire logic [31:0] instr,
    input  wire logic [31:0] instr_pc,
    input  wire logic        stall,
    output logic             retire_valid,
    output logic      [31:0] retire_pc,
    output logic      [31:0] retire_instr,
    output logic             wb_we,
    output logic      [4:0]  wb_rd,
    output logic      [31:0] wb_data,
    output logic             redirect,
    output logic      [31:0] redirect_pc
);

    logic [4:0]  rf_rs1_addr, rf_rs2_addr;
    logic [31:0] rf_rs1_data, rf_rs2_data;

    logic        id_valid, id_reg_we, id_a_sel, id_b_sel, id_wb_sel;
    logic        id_is_branch, id_is_jal, id_is_jalr;
    logic [31:0] id_pc, id_rs1_data, id_rs2_data, id_imm;
    logic [4:0]  id_rd;
    logic [3:0]  id_alu_op;
    logic [2:0]  id_funct3;

    logic        ex_valid, ex_reg_we, ex_a_sel, ex_b_sel, ex_wb_sel;
    logic        ex_is_branch, ex_is_jal, ex_is_jalr;
    logic [31:0] ex_pc, ex_instr, ex_rs1_data, ex_rs2_data, ex_imm;
    logic [4:0]  ex_rs1_addr, ex_rs2_addr, ex_rd;
    logic [3:0]  ex_alu_op;
    logic [2:0]  ex_funct3;
    logic        flush;

    regfile u_regfile (
        .clk, .rst,
        .rs1_addr (rf_rs1_addr), .rs2_addr (rf_rs2_addr),
        .rs1_data (rf_rs1_data), .rs2_data (rf_rs2_data),
        .we (wb_we), .rd (wb_rd), .wd (wb_data)
    );

    id_decode u_id_decode (
        .instr, .instr_valid, .instr_pc,
        .rs1_addr (rf_rs1_addr), .rs2_addr (rf_rs2_addr),
        .rs1_rdata (rf_rs1_data), .rs2_rdata (rf_rs2_data),
        .valid (id_valid), .pc (id_pc),
        .rs1_data (id_rs1_data), .rs2_data (id_rs2_data),
        .imm (id_imm), .rd (id_rd), .reg_we (id_reg_we), .alu_op (id_alu_op),
        .a_sel (id_a_sel), .b_sel (id_b_sel), .wb_sel (id_wb_sel),
        .is_branch (id_is_branch), .is_jal (id_is_jal), .is_jalr (id_is_jalr),
        .funct3 (id_funct3)
    );

    // the raw word rides along in ID/EX for the retire report
    id_ex_reg u_id_ex_reg (
        .clk, .rst, .stall, .flush,
        .id_valid, .id_pc, .id_instr (instr), .id_rs1_data, .id_rs2_data,
        .id_rs1_addr (rf_rs1_addr), .id_rs2_addr (rf_rs2_addr),
        .id_imm, .id_rd, .id_reg_we, .id_alu_op, .id_a_sel, .id_b_sel, .id_wb_sel,
        .id_is_branch, .id_is_jal, .id_is_jalr, .id_funct3,
        .ex_valid, .ex_pc, .ex_instr, .ex_rs1_data, .ex_rs2_data,
        .ex_rs1_addr, .ex_rs2_addr, .ex_imm, .ex_rd, .ex_reg_we, .ex_alu_op,
        .ex_a_sel, .ex_b_sel, .ex_wb_sel, .ex_is_branch, .ex_is_jal, .ex_is_jalr,
        .ex_funct3
    );

    ex_stage u_ex_stage (
        .clk, .rst, .stall,
        .ex_valid, .ex_pc, .ex_instr, .ex_rs1_data, .ex_rs2_data,
        .ex_rs1_addr, .ex_rs2_addr, .ex_imm, .ex_rd, .ex_reg_we, .ex_alu_op,
        .ex_a_sel, .ex_b_sel, .ex_wb_sel, .ex_is_branch, .ex_is_jal, .ex_is_jalr,
        .ex_funct3,
        .flush,
        .wb_we, .wb_rd, .wb_data,
        .retire_valid, .retire_pc, .retire_instr,
        .redirect, .redirect_pc
    );

endmodule

`default_nettype wire

//--- tb_exec_pipe.sv
`default_nettype none

module tb_exec_pipe;

    localparam int n_cycles       = 3000;
    localparam int rst_cycles     = 16;
    localparam int timeout_cycles = n_cycles + n_cycles / 3; // stalls plus drain margin

    logic        clk = 1'b0;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] instr_pc;
    logic        stall;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [31:0] retire_instr;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        redirect;
    logic [31:0] redirect_pc;

    // expected retire records, filled at accept, drained at retire
    logic [31:0] exp_pc    [0:4095];
    logic [31:0] exp_instr [0:4095];
    logic        exp_we    [0:4095];
    logic [4:0]  exp_rd    [0:4095];
    logic [31:0] exp_data  [0:4095];
    logic        exp_redir [0:4095];
    logic [31:0] exp_tgt   [0:4095];
    int          exp_acc   [0:4095]; // cycle of the accepting edge
    int          exp_stl   [0:4095];
    logic [11:0] head = '0;
    logic [11:0] tail = '0;

    logic [31:0] xreg [0:31];
    logic [31:0] next_pc = 32'd0;
    logic        squash = 1'b0;
    logic        after_taken = 1'b0;
    logic [31:0] taken_pc = 32'd0;
    int          cyc = 0;
    int          stall_cnt = 0;

    exec_pipe_top DUT (
        .clk, .rst, .instr_valid, .instr, .instr_pc, .stall,
        .retire_valid, .retire_pc, .retire_instr,
        .wb_we, .wb_rd, .wb_data, .redirect, .redirect_pc
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic report_mismatch(input string what);
        $display("ERROR at time %0t: %s", $time, what);
        abort_run();
    endtask

    function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] gen_instr();
        rv32i_pkg::instr_u iw;
        int         kind;
        int         pick;
        logic [2:0] f3;
        logic       alt;
        iw   = $urandom();
        kind = $urandom_range(0, 11);
        f3   = 3'($urandom_range(0, 7));
        alt  = 1'($urandom_range(0, 1));
        iw.r_fmt.rd  = 5'($urandom_range(0, 7)); // x0..x7 keeps dependencies dense
        iw.r_fmt.rs1 = 5'($urandom_range(0, 7));
        iw.r_fmt.rs2 = 5'($urandom_range(0, 7));
        case (kind)
            6: iw.u_fmt.opcode = rv32i_pkg::op_lui;
            7: iw.u_fmt.opcode = rv32i_pkg::op_auipc;
            8: iw.j_fmt.opcode = rv32i_pkg::op_jal;
            9: begin
                iw.i_fmt.opcode = rv32i_pkg::op_jalr;
                iw.i_fmt.funct3 = 3'b000;
            end
            10, 11: begin
                pick = $urandom_range(0, 5);
                iw.b_fmt.opcode = rv32i_pkg::op_br;
                iw.b_fmt.funct3 = (pick < 2) ? 3'(pick) : 3'(pick + 2);
            end
            default: begin
                iw.r_fmt.opcode = (kind <= 2) ? rv32i_pkg::op_reg : rv32i_pkg::op_imm;
                iw.r_fmt.funct3 = f3;
                if (f3 == 3'b101 || (f3 == 3'b000 && kind <= 2))
                    iw.r_fmt.funct7 = alt ? 7'h20 : 7'h00;
                else if (kind <= 2 || f3 == 3'b001)
                    iw.r_fmt.funct7 = 7'h00; // slli takes a plain shamt
            end
        endcase
        return iw;
    endfunction

    task automatic present_slot();
        instr       <= gen_instr();
        instr_valid <= ($urandom_range(0, 99) >= 15);
        instr_pc    <= next_pc;
        next_pc = next_pc + 32'd4;
    endtask

    // architectural effect of one accepted, unsquashed slot
    task automatic model_slot(input logic [31:0] w, input logic [31:0] pc);
        logic [31:0] a, b, imm_i, imm_u, imm_b, imm_j, res, tgt;
        logic        we, tk, alt;
        a     = xreg[w[19:15]];
        b     = xreg[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_u = {w[31:12], 12'd0};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        alt   = w[30] && (w[14:12] == 3'b101 || w[6:0] == rv32i_pkg::op_reg);
        we    = 1'b1;
        tk    = 1'b0;
        tgt   = 32'd0;
        case (w[6:0])
            rv32i_pkg::op_reg:   res = alu_result(w[14:12], alt, a, b);
            rv32i_pkg::op_imm:   res = alu_result(w[14:12], alt, a, imm_i);
            rv32i_pkg::op_lui:   res = imm_u;
            rv32i_pkg::op_auipc: res = pc + imm_u;
            rv32i_pkg::op_jal: begin
                res = pc + 32'd4;
                tk  = 1'b1;
                tgt = pc + imm_j;
            end
            rv32i_pkg::op_jalr: begin
                res = pc + 32'd4;
                tk  = 1'b1;
                tgt = (a + imm_i) & ~32'd1;
            end
            default: begin
                res = 32'd0;
                we  = 1'b0;
                tk  = branch_taken(w[14:12], a, b);
                tgt = pc + imm_b;
            end
        endcase
        if (we && w[11:7] != 5'd0) xreg[w[11:7]] = res;
        exp_pc[tail]    <= pc;
        exp_instr[tail] <= w;
        exp_we[tail]    <= we;
        exp_rd[tail]    <= w[11:7];
        exp_data[tail]  <= res;
        exp_redir[tail] <= tk;
        exp_tgt[tail]   <= tgt;
        exp_acc[tail]   <= cyc;
        exp_stl[tail]   <= stall_cnt;
        tail   <= tail + 12'd1;
        squash <= tk;
    endtask

    always @(posedge clk) begin
        if (!rst && !stall) begin
            if (squash) squash <= 1'b0; // slot behind a taken branch or jump
            else if (instr_valid) model_slot(instr, instr_pc);
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (stall) stall_cnt <= stall_cnt + 1;
        if (retire_valid) begin
            head        <= head + 12'd1;
            after_taken <= redirect;
            taken_pc    <= retire_pc;
        end
        if (cyc >= timeout_cycles) begin
            $display("timeout after %0d cycles with %0d retirements still pending",
                     timeout_cycles, tail - head);
            abort_run();
        end
    end

    a_order: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> head != tail && retire_pc == exp_pc[head]
                         && retire_instr == exp_instr[head])
        else report_mismatch($sformatf("retired pc %h instr %h, expected %h %h",
                             retire_pc, retire_instr, exp_pc[head], exp_instr[head]));

    a_writeback: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> wb_we == exp_we[head]
                         && (!exp_we[head] || (wb_rd == exp_rd[head]
                                               && wb_data == exp_data[head])))
        else report_mismatch($sformatf("pc %h writes x%0d=%h we=%b, expected x%0d=%h",
                             retire_pc, wb_rd, wb_data, wb_we, exp_rd[head], exp_data[head]));

    a_redirect: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> redirect == exp_redir[head]
                         && (!exp_redir[head] || redirect_pc == exp_tgt[head]))
        else report_mismatch($sformatf("pc %h redirect %b to %h, expected %b to %h",
                             retire_pc, redirect, redirect_pc, exp_redir[head], exp_tgt[head]));

    a_latency: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> (cyc - exp_acc[head]) == 2 + (stall_cnt - exp_stl[head]))
        else report_mismatch($sformatf("pc %h retired at the wrong cycle", retire_pc));

    a_squashed: assert property (@(posedge clk) disable iff (rst)
        retire_valid && after_taken |-> retire_pc != taken_pc + 32'd4)
        else report_mismatch($sformatf("slot %h behind a taken jump retired", retire_pc));

    a_stall_bubble: assert property (@(posedge clk) disable iff (rst)
        stall |=> !retire_valid && !wb_we && !redirect)
        else report_mismatch("retirement after a stall edge");

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        !retire_valid |-> !wb_we && !redirect)
        else report_mismatch("write or redirect without a retirement");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !retire_valid && !wb_we && !redirect)
        else report_mismatch("outputs active after reset");

    initial begin
        rst         = 1'b1;
        stall       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'd0;
        instr_pc    = 32'd0;
        foreach (xreg[i]) xreg[i] = 32'd0;
        void'($urandom(32'hd90d));
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;
        present_slot();
        for (int n = 1; n < n_cycles; n++) begin
            @(posedge clk);
            if (!stall) present_slot(); // a stalled slot is held
            stall <= (n < n_cycles - 1) && ($urandom_range(0, 99) < 10);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        @(posedge clk);
        while (head != tail) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
rv32i_pkg.sv
regfile.sv
id_decode.sv
id_ex_reg.sv
ex_stage.sv
exec_pipe_top.sv
tb_exec_pipe.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_exec_pipe
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
